/* rtl/bru_pkg.sv */
`default_nettype none

package bru_pkg;

  localparam int XLEN_W   = 32;
  localparam int VADDR_W  = 32;
  localparam int RNID_W   = 6;
  localparam int CMT_ID_W = 5;
  localparam int GRP_ID_W = 4;

  // branch operation after decode.
  typedef enum logic [2:0] {
    OP_EQ   = 3'd0,
    OP_NE   = 3'd1,
    OP_LT   = 3'd2,
    OP_GE   = 3'd3,
    OP_LTU  = 3'd4,
    OP_GEU  = 3'd5,
    OP_JUMP = 3'd6,
    OP_NONE = 3'd7
  } op_t;

  // immediate layout used to form the target.
  typedef enum logic [1:0] {
    IMM_SB   = 2'd0,
    IMM_UJ   = 2'd1,
    IMM_I    = 2'd2,
    IMM_NONE = 2'd3
  } imm_t;

  // rv32i major opcodes.
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  // funct3 codes of the conditional branches.
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

`default_nettype wire

/* rtl/bru_decode.sv */
`default_nettype none

module bru_decode
  import bru_pkg::*;
(
  input  logic [31:0] i_inst,
  output op_t         o_op,
  output imm_t        o_imm
);

  logic [6:0] w_opcode;
  logic [2:0] w_funct3;

  assign w_opcode = i_inst[6:0];
  assign w_funct3 = i_inst[14:12];

  always_comb begin
    o_op  = OP_NONE;
    o_imm = IMM_NONE;
    case (w_opcode)
      OPC_BRANCH: begin
        o_imm = IMM_SB;
        case (w_funct3)
          F3_BEQ:  o_op = OP_EQ;
          F3_BNE:  o_op = OP_NE;
          F3_BLT:  o_op = OP_LT;
          F3_BGE:  o_op = OP_GE;
          F3_BLTU: o_op = OP_LTU;
          F3_BGEU: o_op = OP_GEU;
          // funct3 010 and 011 are reserved.
          default: begin
            o_op  = OP_NONE;
            o_imm = IMM_NONE;
          end
        endcase
      end
      OPC_JAL: begin
        o_op  = OP_JUMP;
        o_imm = IMM_UJ;
      end
      OPC_JALR: begin
        if (w_funct3 == 3'b000) begin
          o_op  = OP_JUMP;
          o_imm = IMM_I;
        end
      end
      default: begin
        o_op  = OP_NONE;
        o_imm = IMM_NONE;
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/bru_operand_fwd.sv */
`default_nettype none

module bru_operand_fwd
  import bru_pkg::*;
#(
  parameter int TGT_BUS_SIZE = 3
) (
  input  logic                             i_src_valid,
  input  logic [RNID_W-1:0]                i_src_rnid,
  input  logic [XLEN_W-1:0]                i_rf_data,
  input  logic [TGT_BUS_SIZE-1:0]          i_wb_valid,
  input  logic [TGT_BUS_SIZE*RNID_W-1:0]   i_wb_rnid,
  input  logic [TGT_BUS_SIZE*XLEN_W-1:0]   i_wb_data,
  output logic [XLEN_W-1:0]                o_data
);

  logic [TGT_BUS_SIZE-1:0] w_match;
  logic [XLEN_W-1:0]       w_fwd_data;

  for (genvar b = 0; b < TGT_BUS_SIZE; b++) begin : g_match
    assign w_match[b] = i_src_valid & i_wb_valid[b] &
                        (i_wb_rnid[b*RNID_W +: RNID_W] == i_src_rnid);
  end

  // tags on the buses are unique, so at most one match bit is set.
  always_comb begin
    w_fwd_data = '0;
    for (int b = 0; b < TGT_BUS_SIZE; b++) begin
      w_fwd_data = w_fwd_data | ({XLEN_W{w_match[b]}} & i_wb_data[b*XLEN_W +: XLEN_W]);
    end
  end

  assign o_data = |w_match ? w_fwd_data : i_rf_data;

endmodule

`default_nettype wire

/* rtl/bru_execute.sv */
`default_nettype none

module bru_execute
  import bru_pkg::*;
(
  input  op_t                i_op,
  input  imm_t               i_imm,
  input  logic [31:0]        i_inst,
  input  logic [VADDR_W-1:0] i_pc,
  input  logic [XLEN_W-1:0]  i_rs1_data,
  input  logic [XLEN_W-1:0]  i_rs2_data,
  output logic               o_taken,
  output logic [VADDR_W-1:0] o_target
);

  logic [VADDR_W-1:0] w_offset_sb;
  logic [VADDR_W-1:0] w_offset_uj;
  logic [XLEN_W-1:0]  w_offset_i;
  logic [XLEN_W-1:0]  w_jalr_sum;
  logic               w_eq;
  logic               w_lt;
  logic               w_ltu;

  assign w_eq  = i_rs1_data == i_rs2_data;
  assign w_lt  = $signed(i_rs1_data) < $signed(i_rs2_data);
  assign w_ltu = i_rs1_data < i_rs2_data;

  always_comb begin
    case (i_op)
      OP_EQ:   o_taken = w_eq;
      OP_NE:   o_taken = ~w_eq;
      OP_LT:   o_taken = w_lt;
      OP_GE:   o_taken = ~w_lt;
      OP_LTU:  o_taken = w_ltu;
      OP_GEU:  o_taken = ~w_ltu;
      OP_JUMP: o_taken = 1'b1;
      default: o_taken = 1'b0;
    endcase
  end

  // b-type and j-type offsets are in units of two bytes.
  assign w_offset_sb = {{(VADDR_W-13){i_inst[31]}},
                        i_inst[31],
                        i_inst[7],
                        i_inst[30:25],
                        i_inst[11:8],
                        1'b0};

  assign w_offset_uj = {{(VADDR_W-21){i_inst[31]}},
                        i_inst[31],
                        i_inst[19:12],
                        i_inst[20],
                        i_inst[30:21],
                        1'b0};

  assign w_offset_i = {{(XLEN_W-12){i_inst[31]}}, i_inst[31:20]};
  assign w_jalr_sum = i_rs1_data + w_offset_i;

  always_comb begin
    case (i_imm)
      IMM_SB:  o_target = i_pc + w_offset_sb;
      IMM_UJ:  o_target = i_pc + w_offset_uj;
      // jalr clears the lowest bit of the sum.
      IMM_I:   o_target = {w_jalr_sum[VADDR_W-1:1], 1'b0};
      default: o_target = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/bru_result.sv */
`default_nettype none

module bru_result
  import bru_pkg::*;
#(
  parameter int RV_ENTRY_SIZE = 8
) (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_valid,
  input  logic [RV_ENTRY_SIZE-1:0] i_index,
  input  logic                     i_taken,
  input  logic [VADDR_W-1:0]       i_target,
  input  logic [VADDR_W-1:0]       i_pc,
  input  logic                     i_rd_valid,
  input  logic [RNID_W-1:0]        i_rd_rnid,
  input  logic [CMT_ID_W-1:0]      i_cmt_id,
  input  logic [GRP_ID_W-1:0]      i_grp_id,
  output logic                     o_done,
  output logic [RV_ENTRY_SIZE-1:0] o_done_index_oh,
  output logic                     o_br_upd_valid,
  output logic [VADDR_W-1:0]       o_br_upd_vaddr,
  output logic [CMT_ID_W-1:0]      o_br_upd_cmt_id,
  output logic [GRP_ID_W-1:0]      o_br_upd_grp_id,
  output logic                     o_wb_valid,
  output logic [RNID_W-1:0]        o_wb_rnid,
  output logic [XLEN_W-1:0]        o_wb_data
);

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_done         <= 1'b0;
      o_br_upd_valid <= 1'b0;
      o_wb_valid     <= 1'b0;
    end else begin
      o_done         <= i_valid;
      o_br_upd_valid <= i_valid & i_taken;
      o_wb_valid     <= i_valid & i_rd_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    o_done_index_oh <= i_index;
    o_br_upd_vaddr  <= i_target;
    o_br_upd_cmt_id <= i_cmt_id;
    o_br_upd_grp_id <= i_grp_id;
    o_wb_rnid       <= i_rd_rnid;
    // link address of the jump.
    o_wb_data       <= XLEN_W'(i_pc + VADDR_W'(4));
  end

endmodule

`default_nettype wire

/* rtl/bru_pipe.sv */
`default_nettype none

module bru_pipe
  import bru_pkg::*;
#(
  parameter int RV_ENTRY_SIZE = 8,
  parameter int TGT_BUS_SIZE  = 3
) (
  input  logic                           i_clk,
  input  logic                           i_reset_n,
  input  logic                           i_rv_valid,
  input  logic [31:0]                    i_rv_inst,
  input  logic [VADDR_W-1:0]             i_rv_pc,
  input  logic [RV_ENTRY_SIZE-1:0]       i_rv_index,
  input  logic                           i_rv_rs1_valid,
  input  logic [RNID_W-1:0]              i_rv_rs1_rnid,
  input  logic                           i_rv_rs2_valid,
  input  logic [RNID_W-1:0]              i_rv_rs2_rnid,
  input  logic                           i_rv_rd_valid,
  input  logic [RNID_W-1:0]              i_rv_rd_rnid,
  input  logic [CMT_ID_W-1:0]            i_rv_cmt_id,
  input  logic [GRP_ID_W-1:0]            i_rv_grp_id,
  output logic                           o_rs1_rd_valid,
  output logic [RNID_W-1:0]              o_rs1_rd_rnid,
  input  logic [XLEN_W-1:0]              i_rs1_rd_data,
  output logic                           o_rs2_rd_valid,
  output logic [RNID_W-1:0]              o_rs2_rd_rnid,
  input  logic [XLEN_W-1:0]              i_rs2_rd_data,
  input  logic [TGT_BUS_SIZE-1:0]        i_wb_valid,
  input  logic [TGT_BUS_SIZE*RNID_W-1:0] i_wb_rnid,
  input  logic [TGT_BUS_SIZE*XLEN_W-1:0] i_wb_data,
  output logic                           o_early_wr_valid,
  output logic [RNID_W-1:0]              o_early_wr_rnid,
  output logic                           o_done,
  output logic [RV_ENTRY_SIZE-1:0]       o_done_index_oh,
  output logic                           o_br_upd_valid,
  output logic [VADDR_W-1:0]             o_br_upd_vaddr,
  output logic [CMT_ID_W-1:0]            o_br_upd_cmt_id,
  output logic [GRP_ID_W-1:0]            o_br_upd_grp_id,
  output logic                           o_wb_valid,
  output logic [RNID_W-1:0]              o_wb_rnid,
  output logic [XLEN_W-1:0]              o_wb_data
);

  op_t                      w_ex0_op;
  imm_t                     w_ex0_imm;

  logic                     r_ex1_valid, r_ex2_valid;
  op_t                      r_ex1_op, r_ex2_op;
  imm_t                     r_ex1_imm, r_ex2_imm;
  logic                     r_ex1_rs1_valid, r_ex2_rs1_valid;
  logic                     r_ex1_rs2_valid, r_ex2_rs2_valid;
  logic                     r_ex1_rd_valid, r_ex2_rd_valid;
  logic [31:0]              r_ex1_inst, r_ex2_inst;
  logic [VADDR_W-1:0]       r_ex1_pc, r_ex2_pc;
  logic [RV_ENTRY_SIZE-1:0] r_ex1_index, r_ex2_index;
  logic [RNID_W-1:0]        r_ex1_rs1_rnid, r_ex2_rs1_rnid;
  logic [RNID_W-1:0]        r_ex1_rs2_rnid, r_ex2_rs2_rnid;
  logic [RNID_W-1:0]        r_ex1_rd_rnid, r_ex2_rd_rnid;
  logic [CMT_ID_W-1:0]      r_ex1_cmt_id, r_ex2_cmt_id;
  logic [GRP_ID_W-1:0]      r_ex1_grp_id, r_ex2_grp_id;
  logic [XLEN_W-1:0]        r_ex2_rs1_rf_data, r_ex2_rs2_rf_data;

  logic [XLEN_W-1:0]        w_ex2_rs1_data, w_ex2_rs2_data;
  logic                     w_ex2_taken;
  logic [VADDR_W-1:0]       w_ex2_target;

  bru_decode u_decode (
    .i_inst (i_rv_inst),
    .o_op   (w_ex0_op),
    .o_imm  (w_ex0_imm)
  );

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_valid     <= 1'b0;
      r_ex1_op        <= OP_NONE;
      r_ex1_imm       <= IMM_NONE;
      r_ex1_rs1_valid <= 1'b0;
      r_ex1_rs2_valid <= 1'b0;
      r_ex1_rd_valid  <= 1'b0;
      r_ex2_valid     <= 1'b0;
      r_ex2_op        <= OP_NONE;
      r_ex2_imm       <= IMM_NONE;
      r_ex2_rs1_valid <= 1'b0;
      r_ex2_rs2_valid <= 1'b0;
      r_ex2_rd_valid  <= 1'b0;
    end else begin
      r_ex1_valid     <= i_rv_valid;
      r_ex1_op        <= w_ex0_op;
      r_ex1_imm       <= w_ex0_imm;
      r_ex1_rs1_valid <= i_rv_rs1_valid;
      r_ex1_rs2_valid <= i_rv_rs2_valid;
      r_ex1_rd_valid  <= i_rv_rd_valid;
      r_ex2_valid     <= r_ex1_valid;
      r_ex2_op        <= r_ex1_op;
      r_ex2_imm       <= r_ex1_imm;
      r_ex2_rs1_valid <= r_ex1_rs1_valid;
      r_ex2_rs2_valid <= r_ex1_rs2_valid;
      r_ex2_rd_valid  <= r_ex1_rd_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex1_inst        <= i_rv_inst;
    r_ex1_pc          <= i_rv_pc;
    r_ex1_index       <= i_rv_index;
    r_ex1_rs1_rnid    <= i_rv_rs1_rnid;
    r_ex1_rs2_rnid    <= i_rv_rs2_rnid;
    r_ex1_rd_rnid     <= i_rv_rd_rnid;
    r_ex1_cmt_id      <= i_rv_cmt_id;
    r_ex1_grp_id      <= i_rv_grp_id;
    r_ex2_inst        <= r_ex1_inst;
    r_ex2_pc          <= r_ex1_pc;
    r_ex2_index       <= r_ex1_index;
    r_ex2_rs1_rnid    <= r_ex1_rs1_rnid;
    r_ex2_rs2_rnid    <= r_ex1_rs2_rnid;
    r_ex2_rd_rnid     <= r_ex1_rd_rnid;
    r_ex2_cmt_id      <= r_ex1_cmt_id;
    r_ex2_grp_id      <= r_ex1_grp_id;
    // register file answers in ex1, held for ex2.
    r_ex2_rs1_rf_data <= i_rs1_rd_data;
    r_ex2_rs2_rf_data <= i_rs2_rd_data;
  end

  assign o_rs1_rd_valid   = r_ex1_valid & r_ex1_rs1_valid;
  assign o_rs1_rd_rnid    = r_ex1_rs1_rnid;
  assign o_rs2_rd_valid   = r_ex1_valid & r_ex1_rs2_valid;
  assign o_rs2_rd_rnid    = r_ex1_rs2_rnid;

  // link value lands two cycles after this wakeup.
  assign o_early_wr_valid = r_ex1_valid & r_ex1_rd_valid;
  assign o_early_wr_rnid  = r_ex1_rd_rnid;

  bru_operand_fwd #(
    .TGT_BUS_SIZE (TGT_BUS_SIZE)
  ) u_rs1_fwd (
    .i_src_valid (r_ex2_rs1_valid),
    .i_src_rnid  (r_ex2_rs1_rnid),
    .i_rf_data   (r_ex2_rs1_rf_data),
    .i_wb_valid  (i_wb_valid),
    .i_wb_rnid   (i_wb_rnid),
    .i_wb_data   (i_wb_data),
    .o_data      (w_ex2_rs1_data)
  );

  bru_operand_fwd #(
    .TGT_BUS_SIZE (TGT_BUS_SIZE)
  ) u_rs2_fwd (
    .i_src_valid (r_ex2_rs2_valid),
    .i_src_rnid  (r_ex2_rs2_rnid),
    .i_rf_data   (r_ex2_rs2_rf_data),
    .i_wb_valid  (i_wb_valid),
    .i_wb_rnid   (i_wb_rnid),
    .i_wb_data   (i_wb_data),
    .o_data      (w_ex2_rs2_data)
  );

  bru_execute u_execute (
    .i_op       (r_ex2_op),
    .i_imm      (r_ex2_imm),
    .i_inst     (r_ex2_inst),
    .i_pc       (r_ex2_pc),
    .i_rs1_data (w_ex2_rs1_data),
    .i_rs2_data (w_ex2_rs2_data),
    .o_taken    (w_ex2_taken),
    .o_target   (w_ex2_target)
  );

  bru_result #(
    .RV_ENTRY_SIZE (RV_ENTRY_SIZE)
  ) u_result (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_valid         (r_ex2_valid),
    .i_index         (r_ex2_index),
    .i_taken         (w_ex2_taken),
    .i_target        (w_ex2_target),
    .i_pc            (r_ex2_pc),
    .i_rd_valid      (r_ex2_rd_valid),
    .i_rd_rnid       (r_ex2_rd_rnid),
    .i_cmt_id        (r_ex2_cmt_id),
    .i_grp_id        (r_ex2_grp_id),
    .o_done          (o_done),
    .o_done_index_oh (o_done_index_oh),
    .o_br_upd_valid  (o_br_upd_valid),
    .o_br_upd_vaddr  (o_br_upd_vaddr),
    .o_br_upd_cmt_id (o_br_upd_cmt_id),
    .o_br_upd_grp_id (o_br_upd_grp_id),
    .o_wb_valid      (o_wb_valid),
    .o_wb_rnid       (o_wb_rnid),
    .o_wb_data       (o_wb_data)
  );

endmodule

`default_nettype wire

/* dv/bru_chk.sv */
`default_nettype none

module bru_chk (
  input logic i_clk,
  input logic i_reset_n,
  input logic i_rv_valid,
  input logic o_rs1_rd_valid,
  input logic o_rs2_rd_valid,
  input logic o_early_wr_valid,
  input logic o_done,
  input logic o_br_upd_valid,
  input logic o_wb_valid
);

  int unsigned fail_count = 0;

  // fixed latency of three cycles.
  issue_done: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_rv_valid |-> ##3 o_done)
    else begin
      fail_count++;
      $error("issue not completed three cycles later");
    end

  update_with_done: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_br_upd_valid |-> o_done)
    else begin
      fail_count++;
      $error("branch update without done");
    end

  // wakeup in ex1 promises the link value in ex3.
  wakeup_then_wb: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_early_wr_valid |-> ##2 o_wb_valid)
    else begin
      fail_count++;
      $error("early wakeup not followed by link writeback");
    end

  quiet_in_reset: assert property (@(posedge i_clk)
    !i_reset_n |-> !(o_done || o_br_upd_valid || o_wb_valid || o_early_wr_valid ||
                     o_rs1_rd_valid || o_rs2_rd_valid))
    else begin
      fail_count++;
      $error("strobe active while in reset");
    end

endmodule

bind bru_pipe bru_chk chk_i (.*);

`default_nettype wire

/* dv/bru_tb.sv */
`default_nettype none

module bru_tb;
  import bru_pkg::*;

  localparam int RV_ENTRY_SIZE = 8;
  localparam int TGT_BUS_SIZE  = 3;
  localparam int NUM_CYCLES    = 400;
  localparam int DRAIN_LIMIT   = 20;

  typedef struct {
    logic                     valid;
    logic [31:0]              inst;
    logic [VADDR_W-1:0]       pc;
    logic [RV_ENTRY_SIZE-1:0] index;
    logic                     rs1_valid;
    logic [RNID_W-1:0]        rs1_rnid;
    logic                     rs2_valid;
    logic [RNID_W-1:0]        rs2_rnid;
    logic                     rd_valid;
    logic [RNID_W-1:0]        rd_rnid;
    logic [CMT_ID_W-1:0]      cmt_id;
    logic [GRP_ID_W-1:0]      grp_id;
    logic                     taken;
    logic [VADDR_W-1:0]       target;
    int                       cycle;
  } issue_t;

  logic                           i_clk;
  logic                           i_reset_n;
  logic                           i_rv_valid;
  logic [31:0]                    i_rv_inst;
  logic [VADDR_W-1:0]             i_rv_pc;
  logic [RV_ENTRY_SIZE-1:0]       i_rv_index;
  logic                           i_rv_rs1_valid;
  logic [RNID_W-1:0]              i_rv_rs1_rnid;
  logic                           i_rv_rs2_valid;
  logic [RNID_W-1:0]              i_rv_rs2_rnid;
  logic                           i_rv_rd_valid;
  logic [RNID_W-1:0]              i_rv_rd_rnid;
  logic [CMT_ID_W-1:0]            i_rv_cmt_id;
  logic [GRP_ID_W-1:0]            i_rv_grp_id;
  logic                           o_rs1_rd_valid;
  logic [RNID_W-1:0]              o_rs1_rd_rnid;
  logic [XLEN_W-1:0]              i_rs1_rd_data;
  logic                           o_rs2_rd_valid;
  logic [RNID_W-1:0]              o_rs2_rd_rnid;
  logic [XLEN_W-1:0]              i_rs2_rd_data;
  logic [TGT_BUS_SIZE-1:0]        i_wb_valid;
  logic [TGT_BUS_SIZE*RNID_W-1:0] i_wb_rnid;
  logic [TGT_BUS_SIZE*XLEN_W-1:0] i_wb_data;
  logic                           o_early_wr_valid;
  logic [RNID_W-1:0]              o_early_wr_rnid;
  logic                           o_done;
  logic [RV_ENTRY_SIZE-1:0]       o_done_index_oh;
  logic                           o_br_upd_valid;
  logic [VADDR_W-1:0]             o_br_upd_vaddr;
  logic [CMT_ID_W-1:0]            o_br_upd_cmt_id;
  logic [GRP_ID_W-1:0]            o_br_upd_grp_id;
  logic                           o_wb_valid;
  logic [RNID_W-1:0]              o_wb_rnid;
  logic [XLEN_W-1:0]              o_wb_data;

  logic [XLEN_W-1:0]       rf [2**RNID_W];
  logic [TGT_BUS_SIZE-1:0] bus_valid;
  logic [RNID_W-1:0]       bus_rnid [TGT_BUS_SIZE];
  logic [XLEN_W-1:0]       bus_data [TGT_BUS_SIZE];
  issue_t                  p1;
  issue_t                  p2;
  issue_t                  exp_q [$];
  int                      seed;
  int                      cyc;
  int                      checks;
  int                      value_errors;
  int                      protocol_errors;
  int                      timeout_errors;

  bru_pipe #(
    .RV_ENTRY_SIZE (RV_ENTRY_SIZE),
    .TGT_BUS_SIZE  (TGT_BUS_SIZE)
  ) dut_i (
    .*
  );

  // register file answers in the same cycle.
  assign i_rs1_rd_data = rf[o_rs1_rd_rnid];
  assign i_rs2_rd_data = rf[o_rs2_rd_rnid];

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    assert (actual === expected)
      else begin
        value_errors++;
        $display("FAIL %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      end
  endtask

  task automatic report_problem(input string what);
    protocol_errors++;
    $display("error at cycle %0d: %s", cyc, what);
  endtask

  // operand values near the sign boundary are favoured.
  function automatic logic [XLEN_W-1:0] pick_value();
    logic [2:0] sel;
    sel = 3'($random(seed));
    case (sel)
      3'd0:    return '0;
      3'd1:    return 32'd1;
      3'd2:    return 32'h7fff_ffff;
      3'd3:    return 32'h8000_0000;
      3'd4:    return 32'hffff_ffff;
      default: return 32'($random(seed));
    endcase
  endfunction

  function automatic issue_t make_issue(input bit allow);
    issue_t     r;
    logic [2:0] kind;
    r.valid    = allow && (4'($random(seed)) != 4'd0);
    kind       = 3'($random(seed));
    r.inst     = 32'($random(seed));
    r.pc       = {30'($random(seed)), 2'b00};
    r.index    = RV_ENTRY_SIZE'(1) << ($unsigned($random(seed)) % RV_ENTRY_SIZE);
    r.rs1_rnid = RNID_W'($random(seed));
    r.rs2_rnid = RNID_W'($random(seed));
    if (3'($random(seed)) == 3'd0) begin
      r.rs2_rnid = r.rs1_rnid;
    end
    r.rd_rnid  = RNID_W'($random(seed));
    r.cmt_id   = CMT_ID_W'($random(seed));
    r.grp_id   = GRP_ID_W'($random(seed));
    r.taken    = 1'b0;
    r.target   = '0;
    r.cycle    = cyc;
    case (kind)
      3'd6: begin
        r.inst[6:0] = OPC_JAL;
        r.rs1_valid = 1'b0;
        r.rs2_valid = 1'b0;
        r.rd_valid  = 2'($random(seed)) != 2'd0;
      end
      3'd7: begin
        r.inst[6:0]   = OPC_JALR;
        r.inst[14:12] = 3'b000;
        r.rs1_valid   = 1'b1;
        r.rs2_valid   = 1'b0;
        r.rd_valid    = 2'($random(seed)) != 2'd0;
      end
      default: begin
        // kinds 0 to 5 map onto beq, bne, blt, bge, bltu, bgeu.
        r.inst[6:0]   = OPC_BRANCH;
        r.inst[14:12] = (kind < 3'd2) ? kind : kind + 3'd2;
        r.rs1_valid   = 1'b1;
        r.rs2_valid   = 1'b1;
        r.rd_valid    = 1'b0;
      end
    endcase
    return r;
  endfunction

  function automatic logic [XLEN_W-1:0] operand(input logic valid,
                                                input logic [RNID_W-1:0] rnid);
    logic [XLEN_W-1:0] val;
    val = rf[rnid];
    for (int b = 0; b < TGT_BUS_SIZE; b++) begin
      if (valid && bus_valid[b] && bus_rnid[b] == rnid) begin
        val = bus_data[b];
      end
    end
    return val;
  endfunction

  // expected outcome from the rv32i branch and jump rules.
  function automatic issue_t resolve(input issue_t r, input logic [XLEN_W-1:0] a,
                                     input logic [XLEN_W-1:0] b);
    logic [XLEN_W-1:0] imm;
    case (r.inst[6:0])
      OPC_JAL: begin
        imm      = {{12{r.inst[31]}}, r.inst[19:12], r.inst[20], r.inst[30:21], 1'b0};
        r.taken  = 1'b1;
        r.target = r.pc + imm;
      end
      OPC_JALR: begin
        imm      = {{20{r.inst[31]}}, r.inst[31:20]};
        r.taken  = 1'b1;
        r.target = (a + imm) & ~32'd1;
      end
      default: begin
        imm = {{20{r.inst[31]}}, r.inst[7], r.inst[30:25], r.inst[11:8], 1'b0};
        case (r.inst[14:12])
          3'b000:  r.taken = a == b;
          3'b001:  r.taken = a != b;
          3'b100:  r.taken = $signed(a) < $signed(b);
          3'b101:  r.taken = $signed(a) >= $signed(b);
          3'b110:  r.taken = a < b;
          3'b111:  r.taken = a >= b;
          default: r.taken = 1'b0;
        endcase
        r.target = r.pc + imm;
      end
    endcase
    return r;
  endfunction

  // drives the ex2 buses, records the expected result and issues the next instruction.
  task automatic step(input bit allow);
    int                fwd1;
    int                fwd2;
    logic [RNID_W-1:0] base;
    issue_t            r;
    cyc++;
    base = RNID_W'($random(seed));
    for (int b = 0; b < TGT_BUS_SIZE; b++) begin
      bus_valid[b] = 1'($random(seed));
      bus_rnid[b]  = base + RNID_W'(b * 21);
      bus_data[b]  = pick_value();
    end
    fwd1 = $unsigned($random(seed)) % (TGT_BUS_SIZE + 1);
    fwd2 = $unsigned($random(seed)) % (TGT_BUS_SIZE + 1);
    if (p2.valid && fwd1 < TGT_BUS_SIZE) begin
      bus_valid[fwd1] = 1'b1;
      bus_rnid[fwd1]  = p2.rs1_rnid;
    end else begin
      fwd1 = TGT_BUS_SIZE;
    end
    if (p2.valid && fwd2 < TGT_BUS_SIZE && fwd2 != fwd1 &&
        !(fwd1 < TGT_BUS_SIZE && p2.rs2_rnid == p2.rs1_rnid)) begin
      bus_valid[fwd2] = 1'b1;
      bus_rnid[fwd2]  = p2.rs2_rnid;
      if (fwd1 < TGT_BUS_SIZE && 2'($random(seed)) == 2'd0) begin
        bus_data[fwd2] = bus_data[fwd1];
      end
    end else begin
      fwd2 = TGT_BUS_SIZE;
    end
    // a tag stays on one valid bus only.
    for (int b = 0; b < TGT_BUS_SIZE; b++) begin
      if (b != fwd1 && b != fwd2 &&
          ((fwd1 < TGT_BUS_SIZE && bus_rnid[b] == bus_rnid[fwd1]) ||
           (fwd2 < TGT_BUS_SIZE && bus_rnid[b] == bus_rnid[fwd2]))) begin
        bus_valid[b] = 1'b0;
      end
      i_wb_valid[b]                   <= bus_valid[b];
      i_wb_rnid[b*RNID_W +: RNID_W]   <= bus_rnid[b];
      i_wb_data[b*XLEN_W +: XLEN_W]   <= bus_data[b];
    end
    if (p2.valid) begin
      exp_q.push_back(resolve(p2, operand(p2.rs1_valid, p2.rs1_rnid),
                              operand(p2.rs2_valid, p2.rs2_rnid)));
    end
    p2 = p1;
    r  = make_issue(allow);
    p1 = r;
    i_rv_valid     <= r.valid;
    i_rv_inst      <= r.inst;
    i_rv_pc        <= r.pc;
    i_rv_index     <= r.index;
    i_rv_rs1_valid <= r.rs1_valid;
    i_rv_rs1_rnid  <= r.rs1_rnid;
    i_rv_rs2_valid <= r.rs2_valid;
    i_rv_rs2_rnid  <= r.rs2_rnid;
    i_rv_rd_valid  <= r.rd_valid;
    i_rv_rd_rnid   <= r.rd_rnid;
    i_rv_cmt_id    <= r.cmt_id;
    i_rv_grp_id    <= r.grp_id;
  endtask

  // ex1 and ex3 outputs are checked on the falling edge.
  always @(negedge i_clk) begin
    issue_t e;
    if (!i_reset_n) begin
      assert (!(o_done | o_br_upd_valid | o_wb_valid | o_early_wr_valid |
                o_rs1_rd_valid | o_rs2_rd_valid))
        else report_problem("output strobe active during reset");
    end else begin
      compare("rs1_rd_valid", 32'(p2.valid & p2.rs1_valid), 32'(o_rs1_rd_valid));
      compare("rs2_rd_valid", 32'(p2.valid & p2.rs2_valid), 32'(o_rs2_rd_valid));
      compare("early_wr_valid", 32'(p2.valid & p2.rd_valid), 32'(o_early_wr_valid));
      if (p2.valid && p2.rs1_valid) begin
        compare("rs1_rd_rnid", 32'(p2.rs1_rnid), 32'(o_rs1_rd_rnid));
      end
      if (p2.valid && p2.rs2_valid) begin
        compare("rs2_rd_rnid", 32'(p2.rs2_rnid), 32'(o_rs2_rd_rnid));
      end
      if (p2.valid && p2.rd_valid) begin
        compare("early_wr_rnid", 32'(p2.rd_rnid), 32'(o_early_wr_rnid));
      end
      if (o_done) begin
        assert (exp_q.size() != 0)
          else report_problem("done pulse with no instruction in flight");
        if (exp_q.size() != 0) begin
          e = exp_q.pop_front();
          compare("done_cycle", 32'(e.cycle + 3), 32'(cyc));
          compare("done_index", 32'(e.index), 32'(o_done_index_oh));
          compare("br_upd_valid", 32'(e.taken), 32'(o_br_upd_valid));
          if (e.taken) begin
            compare("br_upd_vaddr", e.target, o_br_upd_vaddr);
            compare("br_upd_cmt_id", 32'(e.cmt_id), 32'(o_br_upd_cmt_id));
            compare("br_upd_grp_id", 32'(e.grp_id), 32'(o_br_upd_grp_id));
          end
          compare("wb_valid", 32'(e.rd_valid), 32'(o_wb_valid));
          if (e.rd_valid) begin
            compare("wb_rnid", 32'(e.rd_rnid), 32'(o_wb_rnid));
            compare("wb_data", e.pc + 32'd4, o_wb_data);
          end
        end
      end else begin
        compare("idle_br_upd_valid", 32'd0, 32'(o_br_upd_valid));
        compare("idle_wb_valid", 32'd0, 32'(o_wb_valid));
        if (exp_q.size() != 0) begin
          assert (exp_q[0].cycle + 3 > cyc)
            else begin
              report_problem("no done pulse three cycles after issue");
              void'(exp_q.pop_front());
            end
        end
      end
    end
  end

  initial begin
    logic [XLEN_W-1:0] offset;
    int                tmo;
    int                assert_errors;
    seed            = 32'he2da;
    cyc             = 0;
    checks          = 0;
    value_errors    = 0;
    protocol_errors = 0;
    timeout_errors  = 0;
    p1.valid        = 1'b0;
    p2.valid        = 1'b0;
    i_reset_n       = 1'b0;
    i_rv_valid      = 1'b0;
    i_rv_inst       = '0;
    i_rv_pc         = '0;
    i_rv_index      = '0;
    i_rv_rs1_valid  = 1'b0;
    i_rv_rs1_rnid   = '0;
    i_rv_rs2_valid  = 1'b0;
    i_rv_rs2_rnid   = '0;
    i_rv_rd_valid   = 1'b0;
    i_rv_rd_rnid    = '0;
    i_rv_cmt_id     = '0;
    i_rv_grp_id     = '0;
    i_wb_valid      = '0;
    i_wb_rnid       = '0;
    i_wb_data       = '0;
    offset = $random(seed);
    for (int t = 0; t < 2**RNID_W; t++) begin
      rf[t] = 32'(t) * 32'h0400_0041 + offset;
    end
    repeat (4) @(posedge i_clk);
    i_reset_n <= 1'b1;
    for (int n = 0; n < NUM_CYCLES; n++) begin
      @(posedge i_clk);
      step(1'b1);
    end
    tmo = 0;
    while ((exp_q.size() != 0 || p1.valid || p2.valid) && tmo < DRAIN_LIMIT) begin
      @(posedge i_clk);
      step(1'b0);
      tmo++;
    end
    if (exp_q.size() != 0 || p1.valid || p2.valid) begin
      timeout_errors++;
      $display("timeout: pipe did not drain, %0d results still expected", exp_q.size());
    end
    assert_errors = int'(dut_i.chk_i.fail_count);
    $display("checks %0d, errors: value %0d, protocol %0d, timeout %0d, assertion %0d",
             checks, value_errors, protocol_errors, timeout_errors, assert_errors);
    if (value_errors + protocol_errors + timeout_errors + assert_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
rtl/bru_pkg.sv
rtl/bru_decode.sv
rtl/bru_operand_fwd.sv
rtl/bru_execute.sv
rtl/bru_result.sv
rtl/bru_pipe.sv
dv/bru_chk.sv
dv/bru_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := bru_tb
FILELIST := filelist.f
RUNARGS  := +verilator+error+limit+1000

SRCS := $(shell cat $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUNARGS))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
